/* bp_top.f */
+incdir+verilog
verilog/bp_pkg.sv
verilog/bp_commit_queue.sv
verilog/bp_gselect_table.sv
verilog/bp_apb_regs.sv
verilog/bp_top.sv
verif/bp_assertions.sv
verif/bp_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the predictor testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 --top-module bp_tb -f bp_top.f -o bp_sim \
	> build.log 2>&1 \
	&& ./obj_dir/bp_sim > sim.log 2>&1 \
	|| { echo "Build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Verification passed" sim.log && echo "Simulation PASS" \
	|| { echo "Simulation FAIL"; exit 1; }

/* verif/bp_assertions.sv */
/* Concurrent checks bound into the commit queue and the APB slave. Each bind holds
   the group of inputs that its target lacks at idle values */
`default_nettype none
`timescale 1ns/1ps

module bp_assertions (
	input  logic       clk,
	input  logic       rst,
	input  logic [1:0] commit_valid,
	input  logic       commit_ready,
	input  logic       upd_valid,
	input  logic       psel,
	input  logic       penable,
	input  logic       pready
);

	// The sender must hold off while fewer than two entries are free
	commit_legal: assert property (@(posedge clk) disable iff (rst)
		!((|commit_valid) && !commit_ready))
		else $error("commit_valid was high while commit_ready was low");

	// An entry written on this edge is at the head in the next cycle
	head_fill: assert property (@(posedge clk) disable iff (rst) (|commit_valid) |=> upd_valid)
		else $error("upd_valid stayed low in the cycle after a commit");

	// Zero wait states, so a setup phase is followed by an access phase that completes at once
	apb_no_wait: assert property (@(posedge clk) disable iff (rst)
		(psel && !penable) |=> (psel && penable && pready))
		else $error("APB setup phase was not followed by a completing access phase");

endmodule

// The queue sees no APB traffic
bind bp_commit_queue bp_assertions queue_checks_i (
	.clk(clk), .rst(rst), .commit_valid(commit_valid), .commit_ready(commit_ready),
	.upd_valid(upd_valid),
	.psel(1'b0), .penable(1'b0), .pready(1'b1)
);

// The register block sees no commits
bind bp_apb_regs bp_assertions apb_checks_i (
	.clk(clk), .rst(rst), .commit_valid(2'b00), .commit_ready(1'b1),
	.upd_valid(1'b0),
	.psel(psel), .penable(penable), .pready(pready)
);

`default_nettype wire

/* verif/bp_tb.sv */
/* Testbench for bp_top with its own model of the counters and the history.
   Predictions are compared only while the update queue is drained */
`default_nettype none
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_tb;

	localparam int TIMEOUT = 2000;
	localparam int ENTRIES = 1 << `BP_IDX_BITS;
	localparam logic [31:0] PC_A = 32'h0000_1040;
	localparam logic [31:0] PC_B = 32'h0000_20A8;
	localparam logic [31:0] PC_D = 32'h0000_03FC;
	localparam logic [31:0] PC_POOL [0:3] = '{PC_A, PC_B, PC_D, 32'h0000_0124};

	logic                   clk = 1'b0;
	logic                   rst;
	logic [1:0]             commit_valid;
	logic [1:0][`BP_AW-1:0] commit_pc;
	logic [1:0]             commit_taken;
	logic                   commit_ready;
	logic [1:0][`BP_AW-1:0] fetch_pc;
	logic [1:0]             predict_taken;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [11:0]            paddr;
	logic [31:0]            pwdata;
	logic [31:0]            prdata;
	logic                   pready;
	logic                   pslverr;

	// Model of the table, the history and the enable bit
	bp_pkg::ctr_t      model_ctr [0:ENTRIES-1];
	logic [1:0]        model_hist;
	logic              model_en;
	int                touched [$];
	int                exp_updates;
	int                checks;
	int                value_errors;
	int                other_errors;
	// High only while the model and the table are in step
	logic              pred_check;
	logic              rand_fetch;
	logic [`BP_AW-1:0] fixed_pc;

	bp_top dut_i (
		.clk(clk), .rst(rst), .commit_valid(commit_valid), .commit_pc(commit_pc),
		.commit_taken(commit_taken), .commit_ready(commit_ready), .fetch_pc(fetch_pc),
		.predict_taken(predict_taken), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #10 clk = ~clk;

	// ==============================
	// Reference model
	// ==============================

	// Pc bits 8:2 sit above the history bits
	function automatic int model_index(input logic [`BP_AW-1:0] pc, input logic [1:0] h);
		return 32'({pc[`BP_PC_BITS+1:2], h});
	endfunction

	// One resolved branch moves its counter a step and shifts the history
	function automatic bp_pkg::ctr_t model_apply(input logic [`BP_AW-1:0] pc, input logic taken);
		int idx;
		idx = model_index(pc, model_hist);
		if (taken && model_ctr[idx] != 2'd3)
			model_ctr[idx] = model_ctr[idx] + 2'd1;
		else if (!taken && model_ctr[idx] != 2'd0)
			model_ctr[idx] = model_ctr[idx] - 2'd1;
		model_hist = {model_hist[0], taken};
		exp_updates++;
		return model_ctr[idx];
	endfunction

	function automatic logic model_predict(input logic [`BP_AW-1:0] pc);
		return model_en & model_ctr[model_index(pc, model_hist)][1];
	endfunction

	// Half of the lookups hit trained pcs
	function automatic logic [`BP_AW-1:0] pick_fetch_pc();
		if ($urandom_range(1) == 0)
			return PC_POOL[$urandom_range(3)];
		return $urandom;
	endfunction

	// ==============================
	// Checks and reporting
	// ==============================
	task automatic print_counts();
		$display("Checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
	endtask

	task automatic abort_run(input string what);
		other_errors++;
		$display("Timeout while %s", what);
		print_counts();
		$display("Verification failed");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act == exp) else begin
			$display("FAIL t=%0t %s expected=0x%0h actual=0x%0h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	// Both lookups are checked on every rising edge while the model is in step
	always @(posedge clk) begin
		if (pred_check) begin
			for (int s = 0; s < 2; s++) begin
				checks++;
				assert (predict_taken[s] == model_predict(fetch_pc[s])) else begin
					$display("FAIL t=%0t predict_taken[%0d] expected=%0b actual=%0b", $time, s,
						model_predict(fetch_pc[s]), predict_taken[s]);
					value_errors++;
				end
			end
		end
	end

	// Fetch addresses change on every falling edge
	initial begin
		fetch_pc = '0;
		forever begin
			@(negedge clk);
			fetch_pc[0] = rand_fetch ? pick_fetch_pc() : fixed_pc;
			fetch_pc[1] = pick_fetch_pc();
		end
	end

	// ==============================
	// Bus and commit drivers
	// ==============================
	task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int cycles;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		cycles = 0;
		// The response is stable from just after the falling edge up to the completing rising edge
		#1;
		while (!pready) begin
			if (cycles >= TIMEOUT)
				abort_run("waiting for pready");
			cycles++;
			@(negedge clk);
			#1;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused_rd;
		apb_access(1'b1, addr, data, unused_rd, err);
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
		apb_access(1'b0, addr, 32'd0, data, err);
	endtask

	// Enable changes at the access edge and the history clear lands one edge later
	task automatic write_ctrl(input logic [31:0] val);
		logic err;
		logic keep;
		keep = pred_check;
		pred_check = 1'b0;
		apb_write(`BP_REG_CTRL, val, err);
		check_value("pslverr", 32'd0, {31'd0, err});
		@(negedge clk);
		model_en = val[0];
		if (val[1])
			model_hist = 2'b00;
		pred_check = keep;
	endtask

	task automatic wait_status(input int pos, input string what);
		logic [31:0] rd;
		logic err;
		int polls;
		polls = 0;
		do begin
			apb_read(`BP_REG_STATUS, rd, err);
			polls++;
		end while (!rd[pos] && polls < TIMEOUT);
		if (!rd[pos])
			abort_run(what);
	endtask

	task automatic drain_queue();
		wait_status(1, "waiting for the update queue to drain");
		pred_check = 1'b1;
	endtask

	// Slot 0 is the older branch, so the model takes it first
	task automatic drive_commit(input logic [1:0] v, input logic [`BP_AW-1:0] pc0, input logic t0,
			input logic [`BP_AW-1:0] pc1, input logic t1);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!commit_ready) begin
			if (cycles >= TIMEOUT)
				abort_run("waiting for commit_ready");
			cycles++;
			@(negedge clk);
		end
		pred_check = 1'b0;
		commit_valid = v;
		commit_pc[0] = pc0;
		commit_pc[1] = pc1;
		commit_taken = {t1, t0};
		if (v[0]) begin
			touched.push_back(model_index(pc0, model_hist));
			void'(model_apply(pc0, t0));
		end
		if (v[1]) begin
			touched.push_back(model_index(pc1, model_hist));
			void'(model_apply(pc1, t1));
		end
		@(negedge clk);
		commit_valid = 2'b00;
	endtask

	task automatic check_touched();
		logic [31:0] rd;
		logic err;
		foreach (touched[i]) begin
			apb_read(12'(`BP_REG_TABLE_BASE + touched[i] * 4), rd, err);
			check_value("win_ctr", {30'd0, model_ctr[touched[i]]}, rd);
		end
		touched.delete();
	endtask

	task automatic check_updates(input int exp);
		logic [31:0] rd;
		logic err;
		apb_read(`BP_REG_UPDATES, rd, err);
		check_value("UPDATES", 32'(exp), rd);
	endtask

	task automatic train_one(input logic [`BP_AW-1:0] pc, input logic taken);
		drive_commit(2'b01, pc, taken, '0, 1'b0);
		drain_queue();
		check_touched();
	endtask

	// Two outcomes at PC_D set the history to h, then PC_A is looked up
	task automatic history_prediction(input logic [1:0] h, output logic p);
		drive_commit(2'b01, PC_D, h[1], '0, 1'b0);
		drive_commit(2'b01, PC_D, h[0], '0, 1'b0);
		drain_queue();
		check_touched();
		rand_fetch = 1'b0;
		fixed_pc = PC_A;
		repeat (2) @(negedge clk);
		@(posedge clk);
		p = predict_taken[0];
		rand_fetch = 1'b1;
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		logic [31:0]  rd;
		logic         err;
		logic         pred_lo;
		logic         pred_hi;
		int           pairs;
		int           held_updates;
		bp_pkg::ctr_t snap [0:ENTRIES-1];
		void'($urandom(44743));
		rst = 1'b1;
		commit_valid = '0;
		commit_pc = '0;
		commit_taken = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		model_hist = 2'b00;
		model_en = 1'b0;
		exp_updates = 0;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		pred_check = 1'b0;
		rand_fetch = 1'b1;
		fixed_pc = PC_A;
		for (int i = 0; i < ENTRIES; i++)
			model_ctr[i] = 2'd1;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		// Predictions stay low until enable is set
		pred_check = 1'b1;

		wait_status(0, "waiting for the reset sweep to finish");
		for (int i = 0; i < ENTRIES; i++) begin
			apb_read(12'(`BP_REG_TABLE_BASE + i * 4), rd, err);
			check_value("win_ctr", 32'd1, rd);
		end
		check_updates(0);

		// Drive PC_A into 0 first and then up into 3
		write_ctrl(32'd1);
		repeat (3) train_one(PC_A, 1'b0);
		repeat (5) train_one(PC_A, 1'b1);
		check_updates(exp_updates);

		// The same pc must split on the history
		history_prediction(2'b11, pred_hi);
		history_prediction(2'b00, pred_lo);
		check_value("predict_taken history split", 32'd1, {31'd0, pred_hi != pred_lo});

		// Same pc in both slots, then a mixed pair
		drive_commit(2'b11, PC_B, 1'b1, PC_B, 1'b1);
		drain_queue();
		check_touched();
		drive_commit(2'b11, PC_A, 1'b0, PC_B, 1'b0);
		drain_queue();
		check_touched();
		check_updates(exp_updates);

		// Fill the stalled queue until commit_ready drops
		write_ctrl(32'd0);
		held_updates = exp_updates;
		for (int i = 0; i < ENTRIES; i++)
			snap[i] = model_ctr[i];
		pairs = 0;
		while (commit_ready && pairs < `BP_QUEUE_DEPTH) begin
			drive_commit(2'b11, $urandom, 1'($urandom), $urandom, 1'($urandom));
			pairs++;
		end
		check_value("commit_ready pairs", `BP_QUEUE_DEPTH / 2, pairs);
		foreach (touched[i]) begin
			apb_read(12'(`BP_REG_TABLE_BASE + touched[i] * 4), rd, err);
			check_value("win_ctr", {30'd0, snap[touched[i]]}, rd);
		end
		check_updates(held_updates);
		write_ctrl(32'd1);
		drain_queue();
		check_touched();
		check_updates(exp_updates);

		// Unmapped read and a write to a read-only register
		apb_read(12'h010, rd, err);
		check_value("pslverr", 32'd1, {31'd0, err});
		apb_write(`BP_REG_STATUS, 32'd3, err);
		check_value("pslverr", 32'd1, {31'd0, err});
		// A taken branch leaves a nonzero history in front of the clear
		train_one(PC_D, 1'b1);
		// After the clear the history restarts from zero
		write_ctrl(32'd3);
		apb_read(`BP_REG_CTRL, rd, err);
		check_value("prdata CTRL", 32'd1, rd);
		repeat (40) @(negedge clk);

		print_counts();
		if (value_errors == 0 && other_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/bp_apb_regs.sv */
/* APB3 slave with zero wait states. Only CTRL is writable and the table window
   must be accessed with word aligned addresses */
`default_nettype none
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_apb_regs (
	input  logic               clk,
	input  logic               rst,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [11:0]        paddr,
	input  logic [31:0]        pwdata,
	input  logic               sweep_done,
	input  logic               queue_empty,
	input  logic               upd_fire,
	input  bp_pkg::ctr_t       win_ctr,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr,
	output logic               en,
	output logic               hist_clear,
	output bp_pkg::bht_index_t win_index
);

	logic        access;
	logic        sel_ctrl;
	logic        sel_status;
	logic        sel_updates;
	logic        sel_window;
	logic        mapped;
	logic        wr_ctrl;
	logic [31:0] upd_count;

	// ==============================
	// Address decode
	// ==============================

	// Access phase of a transfer, which always completes in this cycle
	assign access = psel & penable;
	assign pready = 1'b1;

	assign sel_ctrl = (paddr == `BP_REG_CTRL);
	assign sel_status = (paddr == `BP_REG_STATUS);
	assign sel_updates = (paddr == `BP_REG_UPDATES);
	// Window covers 0x800 up to 0xFFC
	assign sel_window = (paddr >= `BP_REG_TABLE_BASE) && (paddr[1:0] == 2'b00);
	assign mapped = sel_ctrl | sel_status | sel_updates | sel_window;

	// Word offset inside the window is the flat table index
	assign win_index.flat = paddr[`BP_IDX_BITS+1:2];

	// Error on holes and on any write outside CTRL
	assign pslverr = access & (~mapped | (pwrite & ~sel_ctrl));
	assign wr_ctrl = access & pwrite & sel_ctrl;

	// ==============================
	// Read data
	// ==============================
	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			if (sel_ctrl)
				// Clear bit is a pulse and always reads as zero
				prdata[0] = en;
			else if (sel_status)
				prdata[1:0] = {queue_empty, sweep_done};
			else if (sel_updates)
				prdata = upd_count;
			else if (sel_window)
				prdata[1:0] = win_ctr;
		end
	end

	// ==============================
	// Control and counters
	// ==============================

	// Enable holds its value and the history clear lasts one cycle after the write
	always_ff @(posedge clk) begin
		if (rst) begin
			en <= 1'b0;
			hist_clear <= 1'b0;
		end else begin
			hist_clear <= wr_ctrl & pwdata[1];
			if (wr_ctrl)
				en <= pwdata[0];
		end
	end

	// Counts every counter update applied to the table and wraps at the top
	always_ff @(posedge clk) begin
		if (rst)
			upd_count <= '0;
		else if (upd_fire)
			upd_count <= upd_count + 32'd1;
	end

endmodule

`default_nettype wire

/* verilog/bp_commit_queue.sv */
/* Accepts up to two resolved branches per cycle and retires one per cycle in order.
   The sender must keep commit_valid low while commit_ready is low */
`default_nettype none
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_commit_queue (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic [`BP_COMMIT_SLOTS-1:0]             commit_valid,
	input  logic [`BP_COMMIT_SLOTS-1:0][`BP_AW-1:0] commit_pc,
	input  logic [`BP_COMMIT_SLOTS-1:0]             commit_taken,
	input  logic                                    upd_accept,
	output logic                                    commit_ready,
	output logic                                    upd_valid,
	output logic [`BP_AW-1:0]                       upd_pc,
	output logic                                    upd_taken,
	output logic                                    empty
);

	localparam int PTR_BITS = $clog2(`BP_QUEUE_DEPTH);
	localparam int CNT_BITS = PTR_BITS + 1;

	// Payload storage with no reset since the count says what is valid
	logic [`BP_AW-1:0]   pc_mem [0:`BP_QUEUE_DEPTH-1];
	logic                taken_mem [0:`BP_QUEUE_DEPTH-1];

	logic [PTR_BITS-1:0] head;
	logic [PTR_BITS-1:0] tail;
	logic [PTR_BITS-1:0] slot1_ptr;
	logic [CNT_BITS-1:0] count;
	logic [1:0]          n_wr;
	logic                pop;

	// Slot 0 is older, so it lands at the tail and slot 1 right behind it
	// If only slot 1 is valid it takes the tail itself
	always_comb begin
		n_wr = {1'b0, commit_valid[0]} + {1'b0, commit_valid[1]};
		slot1_ptr = tail + PTR_BITS'(commit_valid[0]);
	end

	// An entry leaves when the table takes it on this edge
	assign pop = upd_valid & upd_accept;

	always_ff @(posedge clk) begin
		if (commit_valid[0]) begin
			pc_mem[tail] <= commit_pc[0];
			taken_mem[tail] <= commit_taken[0];
		end
		if (commit_valid[1]) begin
			pc_mem[slot1_ptr] <= commit_pc[1];
			taken_mem[slot1_ptr] <= commit_taken[1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			tail <= tail + PTR_BITS'(n_wr);
			if (pop)
				head <= head + 1'b1;
			// Both sides can move in one cycle so the count takes the net change
			count <= count + CNT_BITS'(n_wr) - CNT_BITS'(pop);
		end
	end

	// Room for a full pair is required, so a two-wide commit never overflows
	assign commit_ready = (count <= CNT_BITS'(`BP_QUEUE_DEPTH - 2));
	assign empty = (count == '0);
	assign upd_valid = ~empty;
	assign upd_pc = pc_mem[head];
	assign upd_taken = taken_mem[head];

endmodule

`default_nettype wire

/* verilog/bp_consts.svh */
/* Sizes and APB offsets for the gselect predictor. BP_IDX_BITS must stay equal to
   BP_PC_BITS plus BP_HIST_BITS and the queue depth must be a power of two */
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// ==============================
// Table and history geometry
// ==============================

// Instruction address bits used in the index, taken starting at bit 2
`define BP_PC_BITS 7
// Length of the global taken/not-taken history
`define BP_HIST_BITS 2
// Table index width, so the table holds 512 counters
`define BP_IDX_BITS 9

// Fetch lookups and commit inputs handled in one cycle
`define BP_FETCH_SLOTS 2
`define BP_COMMIT_SLOTS 2
// Entries in the in-order update queue
`define BP_QUEUE_DEPTH 16
// Instruction address width
`define BP_AW 32

// ==============================
// APB register offsets
// ==============================
`define BP_REG_CTRL 12'h000
`define BP_REG_STATUS 12'h004
`define BP_REG_UPDATES 12'h008
// The counter window runs from here to 0xFFC with one word per entry
`define BP_REG_TABLE_BASE 12'h800

`endif

/* verilog/bp_gselect_table.sv */
/* 512 two-bit counters indexed by pc bits 8:2 and two bits of global history.
   Predictions stay low until enable is set and the reset sweep has finished */
`default_nettype none
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_gselect_table (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   en,
	input  logic                                   hist_clear,
	input  logic [`BP_FETCH_SLOTS-1:0][`BP_AW-1:0] fetch_pc,
	input  logic                                   upd_valid,
	input  logic [`BP_AW-1:0]                      upd_pc,
	input  logic                                   upd_taken,
	input  bp_pkg::bht_index_t                     win_index,
	output logic [`BP_FETCH_SLOTS-1:0]             predict_taken,
	output logic                                   upd_accept,
	output logic                                   sweep_done,
	output bp_pkg::ctr_t                           win_ctr,
	output logic                                   upd_fire
);

	localparam int ENTRIES = 1 << `BP_IDX_BITS;
	// Every entry starts as weakly not taken
	localparam bp_pkg::ctr_t CTR_WEAK_NT = 2'd1;

	bp_pkg::ctr_t              ctr_mem [0:ENTRIES-1];
	logic [`BP_HIST_BITS-1:0]  hist;
	bp_pkg::bht_index_t        sweep_idx;
	bp_pkg::bht_index_t        upd_idx;
	bp_pkg::bht_index_t        fetch_idx [0:`BP_FETCH_SLOTS-1];
	bp_pkg::ctr_t              upd_cur;
	bp_pkg::ctr_t              upd_next;

	// ==============================
	// Fetch lookups
	// ==============================

	// Word aligned instructions, so the index skips pc bits 1:0
	// The history used here is the one after every pop so far
	always_comb begin
		for (int s = 0; s < `BP_FETCH_SLOTS; s++) begin
			fetch_idx[s].fields.pc_bits = fetch_pc[s][`BP_PC_BITS+1:2];
			fetch_idx[s].fields.hist = hist;
			// Upper counter bit is the direction
			predict_taken[s] = ctr_mem[fetch_idx[s].flat][1] & en & sweep_done;
		end
	end

	// Third read port for the APB window
	assign win_ctr = ctr_mem[win_index.flat];

	// ==============================
	// Update path
	// ==============================

	// Updates wait in the queue while disabled or while the sweep still owns the table
	assign upd_accept = en & sweep_done;
	assign upd_fire = upd_valid & upd_accept;

	always_comb begin
		upd_idx.fields.pc_bits = upd_pc[`BP_PC_BITS+1:2];
		upd_idx.fields.hist = hist;
		upd_cur = ctr_mem[upd_idx.flat];
	end

	// Step one toward the outcome and hold at the ends
	always_comb begin
		upd_next = upd_cur;
		if (upd_taken) begin
			if (upd_cur != 2'd3)
				upd_next = upd_cur + 2'd1;
		end else begin
			if (upd_cur != 2'd0)
				upd_next = upd_cur - 2'd1;
		end
	end

	// The sweep and the update never write together since updates need sweep_done
	always_ff @(posedge clk) begin
		if (!sweep_done)
			ctr_mem[sweep_idx.flat] <= CTR_WEAK_NT;
		else if (upd_fire)
			ctr_mem[upd_idx.flat] <= upd_next;
	end

	// ==============================
	// Sweep and history control
	// ==============================

	// The sweep walks one entry per cycle starting on the first edge after reset
	// After entry 511 is written the done flag rises and stays up
	always_ff @(posedge clk) begin
		if (rst) begin
			sweep_idx <= '0;
			sweep_done <= 1'b0;
		end else if (!sweep_done) begin
			sweep_idx.flat <= sweep_idx.flat + 1'b1;
			if (sweep_idx.flat == '1)
				sweep_done <= 1'b1;
		end
	end

	// Newest outcome enters at bit 0
	// A clear from software wins over a pop in the same cycle
	always_ff @(posedge clk) begin
		if (rst)
			hist <= '0;
		else if (hist_clear)
			hist <= '0;
		else if (upd_fire)
			hist <= {hist[`BP_HIST_BITS-2:0], upd_taken};
	end

endmodule

`default_nettype wire

/* verilog/bp_pkg.sv */
/* Types shared by the predictor blocks. The index layout follows the sizes in
   the constants header */
`default_nettype none
`include "bp_consts.svh"

package bp_pkg;

	// Two-bit saturating counter where values 2 and 3 predict taken
	typedef logic [1:0] ctr_t;

	// Index split into the address part and the history part
	// The history sits in the low bits so that neighbouring entries share a pc
	typedef struct packed {
		logic [`BP_PC_BITS-1:0]   pc_bits;
		logic [`BP_HIST_BITS-1:0] hist;
	} bht_fields_t;

	// The same index word seen either as its two fields or as a flat address
	// The table builds lookups through the fields view
	// The APB window and the reset sweep step through the flat view
	typedef union packed {
		bht_fields_t             fields;
		logic [`BP_IDX_BITS-1:0] flat;
	} bht_index_t;

endpackage

`default_nettype wire

/* verilog/bp_top.sv */
/* Predictor top level with one clock and synchronous reset. Commit inputs are
   only legal while commit_ready is high */
`default_nettype none
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_top (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic [`BP_COMMIT_SLOTS-1:0]             commit_valid,
	input  logic [`BP_COMMIT_SLOTS-1:0][`BP_AW-1:0] commit_pc,
	input  logic [`BP_COMMIT_SLOTS-1:0]             commit_taken,
	output logic                                    commit_ready,
	input  logic [`BP_FETCH_SLOTS-1:0][`BP_AW-1:0]  fetch_pc,
	output logic [`BP_FETCH_SLOTS-1:0]              predict_taken,
	input  logic                                    psel,
	input  logic                                    penable,
	input  logic                                    pwrite,
	input  logic [11:0]                             paddr,
	input  logic [31:0]                             pwdata,
	output logic [31:0]                             prdata,
	output logic                                    pready,
	output logic                                    pslverr
);

	// Queue head to table
	logic               upd_valid;
	logic [`BP_AW-1:0]  upd_pc;
	logic               upd_taken;
	logic               upd_accept;
	logic               upd_fire;
	logic               queue_empty;
	// Table and register block
	logic               sweep_done;
	logic               en;
	logic               hist_clear;
	bp_pkg::bht_index_t win_index;
	bp_pkg::ctr_t       win_ctr;

	bp_commit_queue queue_i (
		.clk(clk), .rst(rst),
		.commit_valid(commit_valid), .commit_pc(commit_pc), .commit_taken(commit_taken),
		.upd_accept(upd_accept), .commit_ready(commit_ready),
		.upd_valid(upd_valid), .upd_pc(upd_pc), .upd_taken(upd_taken),
		.empty(queue_empty)
	);

	bp_gselect_table table_i (
		.clk(clk), .rst(rst), .en(en), .hist_clear(hist_clear),
		.fetch_pc(fetch_pc), .upd_valid(upd_valid), .upd_pc(upd_pc),
		.upd_taken(upd_taken), .win_index(win_index),
		.predict_taken(predict_taken), .upd_accept(upd_accept),
		.sweep_done(sweep_done), .win_ctr(win_ctr), .upd_fire(upd_fire)
	);

	bp_apb_regs regs_i (
		.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .sweep_done(sweep_done),
		.queue_empty(queue_empty), .upd_fire(upd_fire), .win_ctr(win_ctr),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.en(en), .hist_clear(hist_clear), .win_index(win_index)
	);

endmodule

`default_nettype wire
